/* hw/fetch_pkg.sv */
package fetch_pkg;

	// ====================
	// Widths
	// ====================

	typedef logic [15:0] word_t;      // One instruction word.
	typedef logic [25:0] addr_t;      // Byte address with bit 0 kept clear.
	typedef logic [4:0]  count_t;     // Queue occupancy 0 to 16.
	typedef logic [2:0]  offset_t;    // Word slot inside a line.
	typedef logic [2:0]  consume_t;   // Words taken by the decoder per cycle.

	// ====================
	// Sizes and constants
	// ====================

	localparam int LINE_WORDS  = 8;   // Words per memory line.
	localparam int QUEUE_DEPTH = 16;
	localparam int HEAD_WORDS  = 4;   // Words shown to the decoder.

	localparam addr_t RESET_ADDRESS = 26'h7FE0;

	// Bits 15 to 11 of every jump instruction.
	localparam logic [4:0] JUMP_PREFIX = 5'h1F;

	// ====================
	// Encodings
	// ====================

	// Jump kinds held in bits 10 to 8.
	typedef enum logic [2:0] {
		op_jump_direct   = 3'd2,
		op_jump_indirect = 3'd3,
		op_jump_call     = 3'd6
	} jump_kind_e;

	typedef enum logic [1:0] {
		fetch_idle,
		fetch_wait_line,      // Request out and waiting for ack.
		fetch_settle,         // Staged line goes into the queue.
		fetch_stalled_state   // Jump seen and waiting for jump_take.
	} fetch_state_e;

endpackage

/* hw/fetch_line_if.sv */
`timescale 1ns/10ps

interface fetch_line_if;
	import fetch_pkg::*;

	logic    valid;                // Staged line present this cycle.
	word_t   words [LINE_WORDS];
	offset_t first;                // First valid word of the line.
	logic    jump_found;           // A jump sits at or after first.

	modport stage (
		output valid,
		output words,
		output first,
		output jump_found
	);

	modport sink (
		input valid,
		input words,
		input first
	);

	modport watch (
		input valid,
		input jump_found
	);

endinterface

/* hw/fetch_control.sv */
`timescale 1ns/10ps

module fetch_control (
	input  logic              main_clk,
	input  logic              reset,
	input  logic              jump_take,
	input  fetch_pkg::addr_t  jump_address,
	input  logic              mem_ack,
	input  fetch_pkg::count_t queue_count,
	fetch_line_if.watch       watch,
	output logic              mem_request,
	output fetch_pkg::addr_t  mem_address,
	output logic              line_valid,
	output logic              jump_busy,
	output logic              fetch_stalled
);
	import fetch_pkg::*;

	fetch_state_e state;
	addr_t        fetch_address;
	addr_t        jump_saved;
	addr_t        jump_target;
	logic [3:0]   words_left;
	logic         room_ok;

	// A fresh jump wins over one that is still held.
	assign jump_target = jump_take ? (jump_address & ~addr_t'(1)) : jump_saved;

	// Words the next line returns from the current address on.
	assign words_left = 4'(LINE_WORDS) - {1'b0, offset_t'(fetch_address[3:1])};

	// Whole remainder of the line must still fit.
	assign room_ok = ({1'b0, queue_count} + {2'b00, words_left}) < 6'(QUEUE_DEPTH);

	// Data returned under a pending jump is thrown away.
	assign line_valid = (state == fetch_wait_line) && mem_ack && !jump_busy && !jump_take;

	assign mem_address   = fetch_address;
	assign fetch_stalled = (state == fetch_stalled_state);

	// ====================
	// Fetch FSM
	// ====================

	always_ff @(posedge main_clk) begin
		if (reset) begin
			state         <= fetch_idle;
			fetch_address <= RESET_ADDRESS;
			mem_request   <= 1'b0;
			jump_busy     <= 1'b0;
		end else begin
			unique case (state)
				fetch_idle: begin
					if (jump_take) begin
						fetch_address <= jump_target;
						mem_request   <= 1'b1;
						state         <= fetch_wait_line;
					end else if (room_ok) begin
						mem_request <= 1'b1;
						state       <= fetch_wait_line;
					end
				end
				fetch_wait_line: begin
					if (mem_ack) begin
						if (jump_busy || jump_take) begin
							// Reissue at the jump target while the request stays up.
							fetch_address <= jump_target;
							jump_busy     <= 1'b0;
						end else begin
							fetch_address <= (fetch_address & ~addr_t'(2 * LINE_WORDS - 1))
								+ addr_t'(2 * LINE_WORDS); // Next line boundary.
							mem_request   <= 1'b0;
							state         <= fetch_settle;
						end
					end else if (jump_take) begin
						jump_busy <= 1'b1;
					end
				end
				fetch_settle: begin
					if (jump_take) begin
						fetch_address <= jump_target;
						mem_request   <= 1'b1;
						state         <= fetch_wait_line;
					end else if (watch.valid && watch.jump_found) begin
						state <= fetch_stalled_state;
					end else begin
						state <= fetch_idle;
					end
				end
				fetch_stalled_state: begin
					if (jump_take) begin // Only a taken jump ends the stall.
						fetch_address <= jump_target;
						mem_request   <= 1'b1;
						state         <= fetch_wait_line;
					end
				end
			endcase
		end
	end

	// Target held until the outstanding ack arrives.
	always_ff @(posedge main_clk) begin
		if (jump_take) begin
			jump_saved <= jump_address & ~addr_t'(1);
		end
	end

	// ====================
	// Checks
	// ====================

	addr_aligned_a: assert property (
		@(posedge main_clk) disable iff (reset)
		!mem_address[0]
	) else $error("fetch address not word aligned");

	ack_needs_request_a: assert property (
		@(posedge main_clk) disable iff (reset)
		mem_ack |-> mem_request
	) else $error("memory ack without a request");

endmodule

/* hw/line_scan.sv */
`timescale 1ns/10ps

module line_scan (
	input  logic               main_clk,
	input  logic               reset,
	input  logic               jump_take,
	input  logic               line_valid,
	input  fetch_pkg::word_t   mem_words [fetch_pkg::LINE_WORDS],
	input  fetch_pkg::offset_t first,
	fetch_line_if.stage        stage
);
	import fetch_pkg::*;

	word_t   words_q [LINE_WORDS];
	offset_t first_q;
	logic    valid_q;
	logic    jump_q;
	logic    jump_in_line;

	function automatic logic is_jump(word_t w);
		jump_kind_e kind;
		kind = jump_kind_e'(w[10:8]);
		return (w[15:11] == JUMP_PREFIX)
			&& (kind inside {op_jump_direct, op_jump_indirect, op_jump_call});
	endfunction

	// Words ahead of the start offset are not part of this fetch.
	always_comb begin
		jump_in_line = 1'b0;
		for (int i = 0; i < LINE_WORDS; i++) begin
			if (i >= int'(first) && is_jump(mem_words[i])) begin
				jump_in_line = 1'b1;
			end
		end
	end

	always_ff @(posedge main_clk) begin
		if (reset || jump_take) begin
			valid_q <= 1'b0; // Staged line dropped on a jump.
			jump_q  <= 1'b0;
		end else begin
			valid_q <= line_valid;
			jump_q  <= line_valid && jump_in_line;
		end
	end

	always_ff @(posedge main_clk) begin
		if (line_valid) begin
			words_q <= mem_words;
			first_q <= first;
		end
	end

	assign stage.valid      = valid_q;
	assign stage.words      = words_q;
	assign stage.first      = first_q;
	assign stage.jump_found = jump_q;

endmodule

/* hw/instruction_queue.sv */
`timescale 1ns/10ps

module instruction_queue (
	input  logic                main_clk,
	input  logic                reset,
	input  logic                jump_take,
	fetch_line_if.sink          sink,
	input  fetch_pkg::consume_t consume_count,
	output fetch_pkg::word_t    head_words [fetch_pkg::HEAD_WORDS],
	output fetch_pkg::count_t   queue_count
);
	import fetch_pkg::*;

	typedef logic [$clog2(QUEUE_DEPTH)-1:0] ptr_t;

	word_t  storage [QUEUE_DEPTH];
	ptr_t   head_ptr;
	ptr_t   tail_ptr;
	count_t count;
	count_t append_count;

	assign tail_ptr = head_ptr + ptr_t'(count); // A full queue wraps back onto the head.

	assign append_count = sink.valid ? count_t'(LINE_WORDS) - count_t'(sink.first) : '0;

	// ====================
	// Pointers and count
	// ====================

	always_ff @(posedge main_clk) begin
		if (reset || jump_take) begin
			head_ptr <= '0;
			count    <= '0;
		end else begin
			head_ptr <= head_ptr + ptr_t'(consume_count);
			count    <= count - count_t'(consume_count) + append_count;
		end
	end

	// Staged words land right behind the last held word.
	always_ff @(posedge main_clk) begin
		if (sink.valid) begin
			for (int i = 0; i < LINE_WORDS; i++) begin
				if (i >= int'(sink.first)) begin
					storage[tail_ptr + ptr_t'(i) - ptr_t'(sink.first)] <= sink.words[i];
				end
			end
		end
	end

	always_comb begin
		for (int k = 0; k < HEAD_WORDS; k++) begin
			head_words[k] = (count > count_t'(k)) ? storage[head_ptr + ptr_t'(k)] : '0;
		end
	end

	assign queue_count = count;

	// ====================
	// Checks
	// ====================

	consume_in_range_a: assert property (
		@(posedge main_clk) disable iff (reset)
		count_t'(consume_count) <= count
	) else $error("decoder consumed more words than held");

	count_in_range_a: assert property (
		@(posedge main_clk) disable iff (reset)
		count <= count_t'(QUEUE_DEPTH)
	) else $error("queue count above depth");

endmodule

/* hw/prefetch_unit.sv */
`timescale 1ns/10ps

module prefetch_unit (
	input  logic                main_clk,
	input  logic                reset,
	output logic                mem_request,
	output fetch_pkg::addr_t    mem_address,
	input  logic                mem_ack,
	input  fetch_pkg::word_t    mem_words [fetch_pkg::LINE_WORDS],
	input  logic                jump_take,
	input  fetch_pkg::addr_t    jump_address,
	input  fetch_pkg::consume_t consume_count,
	output fetch_pkg::word_t    head_words [fetch_pkg::HEAD_WORDS],
	output fetch_pkg::count_t   queue_count,
	output logic                jump_busy,
	output logic                fetch_stalled
);

	logic line_valid;

	fetch_line_if line_if ();

	fetch_control fetch_control_i (
		.main_clk      (main_clk),
		.reset         (reset),
		.jump_take     (jump_take),
		.jump_address  (jump_address),
		.mem_ack       (mem_ack),
		.queue_count   (queue_count),
		.watch         (line_if.watch),
		.mem_request   (mem_request),
		.mem_address   (mem_address),
		.line_valid    (line_valid),
		.jump_busy     (jump_busy),
		.fetch_stalled (fetch_stalled)
	);

	// Start offset is the word slot of the requested address.
	line_scan line_scan_i (
		.main_clk   (main_clk),
		.reset      (reset),
		.jump_take  (jump_take),
		.line_valid (line_valid),
		.mem_words  (mem_words),
		.first      (mem_address[3:1]),
		.stage      (line_if.stage)
	);

	instruction_queue instruction_queue_i (
		.main_clk      (main_clk),
		.reset         (reset),
		.jump_take     (jump_take),
		.sink          (line_if.sink),
		.consume_count (consume_count),
		.head_words    (head_words),
		.queue_count   (queue_count)
	);

endmodule

/* testbench/prefetch_unit_tb.sv */
`timescale 1ns/10ps

module prefetch_unit_tb;
	import fetch_pkg::*;

	logic     main_clk, reset, mem_request, mem_ack, jump_take, jump_busy, fetch_stalled;
	addr_t    mem_address, jump_address;
	word_t    mem_words [LINE_WORDS];
	word_t    head_words [HEAD_WORDS];
	consume_t consume_count;
	count_t   queue_count;
	word_t    planted [int unsigned];   // Jump words laid over the fill pattern.
	word_t    model [$];                // Expected queue from the head on.
	logic     slow_memory;              // Forces the longest ack delay.
	int       errors;

	prefetch_unit prefetch_unit_i (.*);

	initial begin
		main_clk = 1'b0;
		forever #20 main_clk = ~main_clk;
	end

	// Low 11 bits of the word index never decode as a jump.
	function automatic word_t mem_word(int unsigned index);
		return planted.exists(index) ? planted[index] : word_t'(index & 32'h7FF);
	endfunction

	// ====================
	// Memory responder
	// ====================

	initial begin
		int delay;
		void'($urandom(32'ha7b074f3));
		mem_ack = 1'b0;
		mem_words = '{default: '0};
		forever begin
			@(posedge main_clk);
			if (mem_request) begin
				delay = slow_memory ? 4 : $urandom_range(4, 1);
				repeat (delay - 1) @(posedge main_clk);
				for (int i = 0; i < LINE_WORDS; i++) begin
					mem_words[i] <= mem_word({mem_address[25:4], 3'(i)}); // Whole line.
				end
				mem_ack <= 1'b1;
				@(posedge main_clk);
				mem_ack <= 1'b0;
			end
		end
	end

	// ====================
	// Compare and wait
	// ====================

	task automatic check_count(count_t got, count_t expected, string what);
		if (got !== expected) begin
			errors++;
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic check_addr(addr_t got, addr_t expected, string what);
		if (got !== expected) begin
			errors++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic check_word(word_t got, word_t expected, string what);
		if (got !== expected) begin
			errors++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic check_flag(logic got, logic expected, string what);
		if (got !== expected) begin
			errors++;
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, expected);
		end
	endtask

	function automatic int observe(string which);
		case (which)
			"request": return int'(mem_request);
			"busy":    return int'(jump_busy);
			default:   return int'(queue_count);
		endcase
	endfunction

	task automatic wait_for(string which, int value);
		int cycles;
		cycles = 0;
		while (observe(which) != value && cycles < 30) begin
			@(negedge main_clk);
			cycles++;
		end
		if (observe(which) != value) begin
			errors++;
			$display("timed out at %0t waiting for %s to reach %0d", $time, which, value);
		end
	endtask

	task automatic expect_quiet(int cycles);
		repeat (cycles) begin
			@(negedge main_clk);
			if (mem_request) begin
				errors++;
				$display("memory request made at %0t while fetching should be held off", $time);
			end
		end
	endtask

	task automatic check_heads();
		for (int k = 0; k < HEAD_WORDS; k++) begin
			check_word(head_words[k], (k < model.size()) ? model[k] : '0,
				$sformatf("head word %0d", k));
		end
		check_count(queue_count, count_t'(model.size()), "queue_count");
	endtask

	// Words from the address offset to the end of its line.
	task automatic expect_line(addr_t address);
		for (int i = int'(address[3:1]); i < LINE_WORDS; i++) begin
			model.push_back(mem_word({address[25:4], 3'(i)}));
		end
	endtask

	// ====================
	// Drivers
	// ====================

	task automatic consume(int n);
		@(posedge main_clk);
		consume_count <= consume_t'(n);
		@(posedge main_clk);
		consume_count <= '0;
		repeat (n) begin
			void'(model.pop_front());
		end
		@(negedge main_clk);
		check_heads();
	endtask

	task automatic take_jump(addr_t target);
		@(posedge main_clk);
		jump_take    <= 1'b1;
		jump_address <= target;
		@(posedge main_clk);
		jump_take <= 1'b0;
		model.delete(); // Queue flushed on the jump edge.
		@(negedge main_clk);
		check_heads();
	endtask

	task automatic fetch_line(addr_t address);
		wait_for("request", 1);
		check_addr(mem_address, address, "mem_address");
		expect_line(address);
		wait_for("count", model.size());
		check_heads();
	endtask

	// ====================
	// Directed tests
	// ====================

	task automatic test_reset_and_fill();
		check_count(queue_count, '0, "queue_count after reset");
		check_flag(jump_busy, 1'b0, "jump_busy after reset");
		check_flag(fetch_stalled, 1'b0, "fetch_stalled after reset");
		fetch_line(26'h7FE0);
		expect_quiet(20); // Eight held leave no room for a full line.
		check_heads();
	endtask

	task automatic test_consume();
		consume(3);
		fetch_line(26'h7FF0);
		consume(4);
		consume(1);
		consume(2);
		fetch_line(26'h8000);
	endtask

	task automatic test_jump_idle();
		take_jump(26'h12347); // Bit 0 of the odd address is dropped.
		fetch_line(26'h12346);
		fetch_line(26'h12350);
	endtask

	task automatic test_jump_pending();
		slow_memory = 1'b1;
		consume(4);
		consume(4);
		wait_for("request", 1);
		take_jump(26'h20000);
		check_flag(jump_busy, 1'b1, "jump_busy with request outstanding");
		check_addr(mem_address, 26'h12360, "mem_address before ack");
		wait_for("busy", 0);
		check_flag(mem_request, 1'b1, "mem_request after dropped ack");
		check_addr(mem_address, 26'h20000, "mem_address after dropped ack");
		repeat (3) begin
			@(negedge main_clk);
			check_count(queue_count, '0, "queue_count after dropped ack");
		end
		slow_memory = 1'b0;
		fetch_line(26'h20000);
	endtask

	task automatic test_jump_detect();
		planted[32'h18005] = {5'h1F, 3'd2, 8'h00};
		take_jump(26'h30004);
		fetch_line(26'h30004);
		check_flag(fetch_stalled, 1'b1, "fetch_stalled after jump word");
		expect_quiet(20);
		planted[32'h20001] = {5'h1F, 3'd6, 8'h00}; // Ahead of the start offset.
		take_jump(26'h40006);
		check_flag(fetch_stalled, 1'b0, "fetch_stalled after jump_take");
		fetch_line(26'h40006);
		fetch_line(26'h40010);
		check_flag(fetch_stalled, 1'b0, "fetch_stalled with early jump word");
	endtask

	initial begin
		errors = 0;
		slow_memory = 1'b0;
		reset = 1'b1;
		jump_take = 1'b0;
		jump_address = '0;
		consume_count = '0;
		repeat (10) @(posedge main_clk);
		reset <= 1'b0;
		@(negedge main_clk);
		test_reset_and_fill();
		test_consume();
		test_jump_idle();
		test_jump_pending();
		test_jump_detect();
		$display("closing: %0d errors", errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* tb.f */
hw/fetch_pkg.sv
hw/fetch_line_if.sv
hw/fetch_control.sv
hw/line_scan.sv
hw/instruction_queue.sv
hw/prefetch_unit.sv
testbench/prefetch_unit_tb.sv
